/* logic/dma_rd_pkg.sv */
// --------------------
// shared widths, types and state encodings of the read DMA engine
// --------------------
package dma_rd_pkg;

    // AXI read data bus is four bytes wide, bursts are INCR only
    localparam int BEAT_BYTES = 4;
    localparam int BEAT_SHIFT = 2;

    // a burst never crosses this boundary
    localparam int PAGE_BYTES = 4096;

    typedef logic [15:0] addr_t;
    typedef logic [19:0] len_t;
    typedef logic [7:0]  tag_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  keep_t;
    typedef logic [18:0] beat_cnt_t;
    typedef logic [1:0]  byte_sel_t;
    typedef logic [7:0]  arlen_t;

    typedef enum logic {
        BURST_IDLE,
        BURST_ISSUE
    } burst_state_t;

    typedef enum logic {
        BEAT_IDLE,
        BEAT_READ
    } beat_state_t;

endpackage

/* logic/dma_rd_burst_ctrl.sv */
// --------------------
// descriptor intake, splitting into INCR bursts, AR channel master
// --------------------
module dma_rd_burst_ctrl #(
    parameter int MAX_BURST_LEN = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,

    input  dma_rd_pkg::addr_t     desc_addr,
    input  dma_rd_pkg::len_t      desc_len,
    input  dma_rd_pkg::tag_t      desc_tag,
    input  logic                  desc_valid,
    output logic                  desc_ready,

    output dma_rd_pkg::addr_t     araddr,
    output dma_rd_pkg::arlen_t    arlen,
    output logic                  arvalid,
    input  logic                  arready,

    output dma_rd_pkg::beat_cnt_t cmd_beats,
    output dma_rd_pkg::keep_t     cmd_last_keep,
    output dma_rd_pkg::tag_t      cmd_tag,
    output logic                  cmd_valid,
    input  logic                  cmd_ready
);
    import dma_rd_pkg::*;

    localparam len_t MAX_BURST_BYTES = len_t'(MAX_BURST_LEN * BEAT_BYTES);

    burst_state_t state;

    // address and byte count left after the burst on the AR channel
    addr_t     next_addr;
    len_t      remain;

    addr_t     src_addr;
    len_t      src_remain;
    len_t      page_left;
    len_t      burst_bytes;
    byte_sel_t tail;
    logic      accept;
    logic      load_burst;
    logic      slot_full_next;

    assign accept = (state == BURST_IDLE) && desc_ready && desc_valid;
    assign load_burst = accept ||
        ((state == BURST_ISSUE) && arvalid && arready && (remain != '0));
    assign slot_full_next = cmd_valid && !cmd_ready;
    assign tail = byte_sel_t'(desc_len);

    // burst sizing, the first burst is taken straight from the descriptor
    always_comb begin
        if (state == BURST_IDLE) begin
            src_addr   = desc_addr & ~addr_t'(BEAT_BYTES - 1);
            src_remain = desc_len;
        end else begin
            src_addr   = next_addr;
            src_remain = remain;
        end
        page_left = len_t'(PAGE_BYTES) - (len_t'(src_addr) & len_t'(PAGE_BYTES - 1));
        burst_bytes = src_remain;
        if (burst_bytes > MAX_BURST_BYTES) begin
            burst_bytes = MAX_BURST_BYTES;
        end
        if (burst_bytes > page_left) begin
            burst_bytes = page_left;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= BURST_IDLE;
            desc_ready <= 1'b0;
            arvalid    <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            if (accept) begin
                cmd_valid <= 1'b1;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end

            case (state)
                BURST_IDLE: begin
                    desc_ready <= enable && !slot_full_next;
                    if (accept) begin
                        desc_ready <= 1'b0;
                        arvalid    <= 1'b1;
                        state      <= BURST_ISSUE;
                    end
                end
                BURST_ISSUE: begin
                    // arvalid stays up while more bursts follow
                    if (arvalid && arready && (remain == '0)) begin
                        arvalid    <= 1'b0;
                        desc_ready <= enable && !slot_full_next;
                        state      <= BURST_IDLE;
                    end
                end
                default: begin
                    state <= BURST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_burst) begin
            araddr    <= src_addr;
            arlen     <= arlen_t'((burst_bytes - len_t'(1)) >> BEAT_SHIFT);
            next_addr <= src_addr + addr_t'(burst_bytes);
            remain    <= src_remain - burst_bytes;
        end
        if (accept) begin
            cmd_beats     <= beat_cnt_t'((desc_len - len_t'(1)) >> BEAT_SHIFT);
            // partial last beat keeps only the low bytes
            cmd_last_keep <= (tail == '0) ? '1 : ~(keep_t'('1) << tail);
            cmd_tag       <= desc_tag;
        end
    end

endmodule

/* logic/dma_rd_beat_ctrl.sv */
// --------------------
// R channel beat counter, keep and tlast, completion status
// --------------------
module dma_rd_beat_ctrl (
    input  logic                  clk,
    input  logic                  rst,

    input  dma_rd_pkg::beat_cnt_t cmd_beats,
    input  dma_rd_pkg::keep_t     cmd_last_keep,
    input  dma_rd_pkg::tag_t      cmd_tag,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,

    input  dma_rd_pkg::data_t     rdata,
    input  logic                  rvalid,
    output logic                  rready,

    output dma_rd_pkg::data_t     in_data,
    output dma_rd_pkg::keep_t     in_keep,
    output logic                  in_last,
    output logic                  in_valid,
    input  logic                  ready_early,

    output dma_rd_pkg::tag_t      status_tag,
    output logic                  status_valid
);
    import dma_rd_pkg::*;

    beat_state_t state;

    // beats still to come minus one
    beat_cnt_t beats_left;
    keep_t     last_keep;
    tag_t      tag;
    logic      beat_xfer;
    logic      final_beat;

    assign cmd_ready  = (state == BEAT_IDLE);
    assign beat_xfer  = (state == BEAT_READ) && rvalid && rready;
    assign final_beat = (beats_left == '0);

    assign in_data  = rdata;
    assign in_keep  = final_beat ? last_keep : '1;
    assign in_last  = final_beat;
    assign in_valid = beat_xfer;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= BEAT_IDLE;
            rready       <= 1'b0;
            status_valid <= 1'b0;
        end else begin
            status_valid <= 1'b0;
            case (state)
                BEAT_IDLE: begin
                    rready <= 1'b0;
                    if (cmd_valid) begin
                        rready <= ready_early;
                        state  <= BEAT_READ;
                    end
                end
                BEAT_READ: begin
                    // rready follows the skid prediction so no beat is dropped
                    rready <= ready_early;
                    if (beat_xfer && final_beat) begin
                        rready       <= 1'b0;
                        status_valid <= 1'b1;
                        state        <= BEAT_IDLE;
                    end
                end
                default: begin
                    state <= BEAT_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            beats_left <= cmd_beats;
            last_keep  <= cmd_last_keep;
            tag        <= cmd_tag;
        end else if (beat_xfer) begin
            beats_left <= beats_left - beat_cnt_t'(1);
        end
        if (beat_xfer && final_beat) begin
            status_tag <= tag;
        end
    end

endmodule

/* logic/dma_rd_out_skid.sv */
// --------------------
// two-entry output register stage for the stream
// --------------------
module dma_rd_out_skid (
    input  logic              clk,
    input  logic              rst,

    input  dma_rd_pkg::data_t in_data,
    input  dma_rd_pkg::keep_t in_keep,
    input  logic              in_last,
    input  logic              in_valid,
    output logic              ready_early,

    output dma_rd_pkg::data_t tdata,
    output dma_rd_pkg::keep_t tkeep,
    output logic              tlast,
    output logic              tvalid,
    input  logic              tready
);
    import dma_rd_pkg::*;

    logic  ready_reg;
    logic  temp_valid;
    data_t temp_data;
    keep_t temp_keep;
    logic  temp_last;
    logic  to_out;
    logic  to_temp;
    logic  temp_to_out;

    // ready next cycle unless temp would have to take a second beat
    assign ready_early = tready || (!temp_valid && (!tvalid || !in_valid));

    assign to_out      = ready_reg && (tready || !tvalid);
    assign to_temp     = ready_reg && !tready && tvalid;
    assign temp_to_out = !ready_reg && tready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg  <= 1'b0;
            tvalid     <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (to_out) begin
                tvalid <= in_valid;
            end else if (temp_to_out) begin
                tvalid <= temp_valid;
            end
            if (to_temp) begin
                temp_valid <= in_valid;
            end else if (temp_to_out) begin
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (to_out) begin
            tdata <= in_data;
            tkeep <= in_keep;
            tlast <= in_last;
        end else if (temp_to_out) begin
            tdata <= temp_data;
            tkeep <= temp_keep;
            tlast <= temp_last;
        end
        if (to_temp) begin
            temp_data <= in_data;
            temp_keep <= in_keep;
            temp_last <= in_last;
        end
    end

endmodule

/* logic/dma_rd_top.sv */
// --------------------
// read DMA top level, descriptor in, AXI read out, stream frame out
// --------------------
module dma_rd_top #(
    parameter int MAX_BURST_LEN = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,

    input  dma_rd_pkg::addr_t  desc_addr,
    input  dma_rd_pkg::len_t   desc_len,
    input  dma_rd_pkg::tag_t   desc_tag,
    input  logic               desc_valid,
    output logic               desc_ready,

    output dma_rd_pkg::tag_t   status_tag,
    output logic               status_valid,

    output dma_rd_pkg::addr_t  araddr,
    output dma_rd_pkg::arlen_t arlen,
    output logic               arvalid,
    input  logic               arready,

    input  dma_rd_pkg::data_t  rdata,
    input  logic               rvalid,
    output logic               rready,

    output dma_rd_pkg::data_t  tdata,
    output dma_rd_pkg::keep_t  tkeep,
    output logic               tlast,
    output logic               tvalid,
    input  logic               tready
);
    import dma_rd_pkg::*;

    // one-entry command slot between the AR side and the R side
    beat_cnt_t cmd_beats;
    keep_t     cmd_last_keep;
    tag_t      cmd_tag;
    logic      cmd_valid;
    logic      cmd_ready;

    // beat stage into the output register stage
    data_t     in_data;
    keep_t     in_keep;
    logic      in_last;
    logic      in_valid;
    logic      ready_early;

    dma_rd_burst_ctrl #(
        .MAX_BURST_LEN(MAX_BURST_LEN)
    ) dma_rd_burst_ctrl_inst (
        .*
    );

    dma_rd_beat_ctrl dma_rd_beat_ctrl_inst (
        .*
    );

    dma_rd_out_skid dma_rd_out_skid_inst (
        .*
    );

endmodule

/* testbench/tb_dma_rd_tests.svh */
// --------------------
// compare tasks, stimulus helpers and directed tests
// --------------------
`ifndef TB_DMA_RD_TESTS_SVH
`define TB_DMA_RD_TESTS_SVH

// memory byte at address a is a[7:0] ^ a[15:8] and beats are little endian
function automatic data_t pattern_beat(addr_t a);
    addr_t b;
    data_t d;
    for (int i = 0; i < 4; i++) begin
        b = a + addr_t'(i);
        d[8*i +: 8] = b[7:0] ^ b[15:8];
    end
    return d;
endfunction

task automatic addr_equal(string name, addr_t got, addr_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic arlen_equal(string name, arlen_t got, arlen_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic data_equal(string name, data_t got, data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic keep_equal(string name, keep_t got, keep_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic tag_equal(string name, tag_t got, tag_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic flag_equal(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic clear_queues();
    ar_addr_q.delete();
    ar_len_q.delete();
    t_data_q.delete();
    t_keep_q.delete();
    t_last_q.delete();
    status_q.delete();
endtask

// hold the descriptor until a negedge shows desc_ready so it is taken at the next edge
task automatic send_desc(addr_t a, len_t len, tag_t tag);
    @(negedge clk);
    desc_addr = a;
    desc_len = len;
    desc_tag = tag;
    desc_valid = 1'b1;
    while (!desc_ready) @(negedge clk);
    @(negedge clk);
    desc_valid = 1'b0;
endtask

task automatic wait_status(int n);
    while (status_q.size() < n) @(negedge clk);
    // the last beats may still sit in the output stage
    while (tvalid) @(negedge clk);
    @(negedge clk);
endtask

task automatic verify_frame(int first, addr_t a, len_t len);
    int nb;
    int rem;
    addr_t base;
    keep_t kexp;
    nb = (int'(len) + 3) / 4;
    rem = int'(len) % 4;
    base = a & ~addr_t'(3);
    if (t_data_q.size() < first + nb) begin
        errors++;
        $display("%0t stream frame at %h is short, %0d beats seen", $time, a, t_data_q.size());
        return;
    end
    for (int i = 0; i < nb; i++) begin
        kexp = (i == nb - 1 && rem != 0) ? keep_t'((1 << rem) - 1) : 4'hf;
        data_equal("tdata", t_data_q[first+i], pattern_beat(base + addr_t'(4 * i)));
        keep_equal("tkeep", t_keep_q[first+i], kexp);
        flag_equal("tlast", t_last_q[first+i], logic'(i == nb - 1));
    end
endtask

task automatic report_test(string name, int errors_before);
    $display("%s: %s", name, (errors == errors_before) ? "ok" : "failed");
endtask

task automatic reset_values_test();
    int e0 = errors;
    flag_equal("desc_ready", desc_ready, 1'b0);
    flag_equal("arvalid", arvalid, 1'b0);
    flag_equal("rready", rready, 1'b0);
    flag_equal("tvalid", tvalid, 1'b0);
    flag_equal("status_valid", status_valid, 1'b0);
    report_test("reset_values", e0);
endtask

task automatic simple_read_test();
    int e0 = errors;
    clear_queues();
    send_desc(16'h0102, 20'd8, 8'ha1);
    wait_status(1);
    flag_equal("one_ar", logic'(ar_addr_q.size() == 1), 1'b1);
    addr_equal("araddr", ar_addr_q[0], 16'h0100);
    arlen_equal("arlen", ar_len_q[0], 8'd1);
    flag_equal("two_beats", logic'(t_data_q.size() == 2), 1'b1);
    verify_frame(0, 16'h0100, 20'd8);
    flag_equal("one_status", logic'(status_q.size() == 1), 1'b1);
    tag_equal("status_tag", status_q[0], 8'ha1);
    report_test("simple_read", e0);
endtask

task automatic short_tail_test();
    int e0 = errors;
    clear_queues();
    send_desc(16'h0200, 20'd10, 8'hb2);
    wait_status(1);
    flag_equal("three_beats", logic'(t_data_q.size() == 3), 1'b1);
    verify_frame(0, 16'h0200, 20'd10);
    tag_equal("status_tag", status_q[0], 8'hb2);
    report_test("short_tail", e0);
endtask

task automatic burst_split_test();
    int e0 = errors;
    clear_queues();
    send_desc(16'h0000, 20'd200, 8'hc3);
    wait_status(1);
    flag_equal("four_ars", logic'(ar_addr_q.size() == 4), 1'b1);
    for (int i = 0; i < 4 && i < ar_addr_q.size(); i++) begin
        addr_equal("araddr", ar_addr_q[i], addr_t'(64 * i));
        arlen_equal("arlen", ar_len_q[i], (i == 3) ? 8'd1 : 8'd15);
    end
    flag_equal("fifty_beats", logic'(t_data_q.size() == 50), 1'b1);
    verify_frame(0, 16'h0000, 20'd200);
    report_test("burst_split", e0);
endtask

task automatic page_cross_test();
    int e0 = errors;
    clear_queues();
    send_desc(16'h0fe0, 20'd96, 8'hd4);
    wait_status(1);
    flag_equal("two_ars", logic'(ar_addr_q.size() == 2), 1'b1);
    addr_equal("araddr", ar_addr_q[0], 16'h0fe0);
    arlen_equal("arlen", ar_len_q[0], 8'd7);
    addr_equal("araddr", ar_addr_q[1], 16'h1000);
    arlen_equal("arlen", ar_len_q[1], 8'd15);
    for (int i = 0; i < ar_addr_q.size(); i++) begin
        flag_equal("burst_in_page",
            logic'(int'(ar_addr_q[i] & 16'h0fff) + 4 * (int'(ar_len_q[i]) + 1) <= 4096), 1'b1);
    end
    verify_frame(0, 16'h0fe0, 20'd96);
    report_test("page_cross", e0);
endtask

task automatic backpressure_test();
    int e0 = errors;
    clear_queues();
    rand_ready = 1'b1;
    rand_gaps = 1'b1;
    send_desc(16'h0300, 20'd37, 8'h51);
    send_desc(16'h0400, 20'd64, 8'h52);
    wait_status(2);
    rand_ready = 1'b0;
    rand_gaps = 1'b0;
    flag_equal("beat_count", logic'(t_data_q.size() == 26), 1'b1);
    verify_frame(0, 16'h0300, 20'd37);
    verify_frame(10, 16'h0400, 20'd64);
    flag_equal("two_status", logic'(status_q.size() == 2), 1'b1);
    tag_equal("status_tag", status_q[0], 8'h51);
    tag_equal("status_tag", status_q[1], 8'h52);
    report_test("backpressure", e0);
endtask

task automatic enable_gate_test();
    int e0 = errors;
    clear_queues();
    @(negedge clk);
    enable = 1'b0;
    @(negedge clk);
    desc_addr = 16'h0500;
    desc_len = 20'd12;
    desc_tag = 8'he6;
    desc_valid = 1'b1;
    repeat (20) begin
        @(negedge clk);
        flag_equal("desc_ready", desc_ready, 1'b0);
    end
    flag_equal("no_ar", logic'(ar_addr_q.size() == 0), 1'b1);
    enable = 1'b1;
    while (!desc_ready) @(negedge clk);
    @(negedge clk);
    desc_valid = 1'b0;
    wait_status(1);
    verify_frame(0, 16'h0500, 20'd12);
    tag_equal("status_tag", status_q[0], 8'he6);
    report_test("enable_gate", e0);
endtask

`endif

/* testbench/tb_dma_rd.sv */
// --------------------
// clock, reset, DUT, AXI read slave model, monitors and timeout
// --------------------
module tb_dma_rd;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_rd_pkg::*;

    // the directed tests take a few hundred cycles in all
    localparam int CYCLE_LIMIT = 20000;

    logic clk, rst, enable;
    addr_t desc_addr;
    len_t desc_len;
    tag_t desc_tag;
    logic desc_valid, desc_ready;
    tag_t status_tag;
    logic status_valid;
    addr_t araddr;
    arlen_t arlen;
    logic arvalid, arready;
    data_t rdata;
    logic rvalid, rready;
    data_t tdata;
    keep_t tkeep;
    logic tlast, tvalid, tready;

    int seed = 32'h3cf1_af40;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic rand_ready = 1'b0;
    logic rand_gaps = 1'b0;

    // slave side queue of accepted ARs and the burst being returned
    addr_t sl_addr_q[$];
    arlen_t sl_len_q[$];
    addr_t beat_addr;
    int beats_rem = 0;

    // R handshakes counted at the rising edge and retired at the falling edge
    int r_taken = 0;
    int r_done = 0;

    // monitor queues
    addr_t ar_addr_q[$];
    arlen_t ar_len_q[$];
    data_t t_data_q[$];
    keep_t t_keep_q[$];
    logic t_last_q[$];
    tag_t status_q[$];

    dma_rd_top #(
        .MAX_BURST_LEN(16)
    ) dma_rd_top_inst (
        .*
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (arvalid && arready) begin
            sl_addr_q.push_back(araddr);
            sl_len_q.push_back(arlen);
            ar_addr_q.push_back(araddr);
            ar_len_q.push_back(arlen);
        end
        if (rvalid && rready) begin
            r_taken++;
        end
        if (tvalid && tready) begin
            t_data_q.push_back(tdata);
            t_keep_q.push_back(tkeep);
            t_last_q.push_back(tlast);
        end
        if (status_valid) begin
            status_q.push_back(status_tag);
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // read slave returns beats in AR order with optional gaps
    always @(negedge clk) begin
        if (r_taken != r_done) begin
            r_done++;
            rvalid = 1'b0;
            beat_addr = beat_addr + addr_t'(4);
            beats_rem--;
        end
        if (!rvalid) begin
            if (beats_rem == 0 && sl_addr_q.size() > 0) begin
                beat_addr = sl_addr_q.pop_front();
                beats_rem = int'(sl_len_q.pop_front()) + 1;
            end
            if (beats_rem != 0 && !(rand_gaps && (($random(seed) & 3) == 0))) begin
                rvalid = 1'b1;
                rdata = pattern_beat(beat_addr);
            end
        end
        tready = rand_ready ? 1'(($random(seed) & 1)) : 1'b1;
    end

    `include "tb_dma_rd_tests.svh"

    initial begin
        rst = 1'b1;
        enable = 1'b1;
        desc_addr = '0;
        desc_len = '0;
        desc_tag = '0;
        desc_valid = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rvalid = 1'b0;
        tready = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        arready = 1'b1;
        reset_values_test();
        simple_read_test();
        short_tail_test();
        burst_split_test();
        page_cross_test();
        backpressure_test();
        enable_gate_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
logic/dma_rd_pkg.sv
logic/dma_rd_burst_ctrl.sv
logic/dma_rd_beat_ctrl.sv
logic/dma_rd_out_skid.sv
logic/dma_rd_top.sv
testbench/tb_dma_rd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the read DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -f vlog.f --top-module tb_dma_rd -o sim_dma_rd
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_dma_rd > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
echo "simulation reported failure"
exit 1
